// File: tb/sd_stim.txt
// Sector bytes 0 to 511, sixteen per line
// Last line: test index, then test byte
3c 3d 3e 3f 38 39 3a 3b 34 35 36 37 30 31 32 33
2c 2d 2e 2f 28 29 2a 2b 24 25 26 27 20 21 22 23
1c 1d 1e 1f 18 19 1a 1b 14 15 16 17 10 11 12 13
0c 0d 0e 0f 08 09 0a 0b 04 05 06 07 00 01 02 03
7c 7d 7e 7f 78 79 7a 7b 74 75 76 77 70 71 72 73
6c 6d 6e 6f 68 69 6a 6b 64 65 66 67 60 61 62 63
5c 5d 5e 5f 58 59 5a 5b 54 55 56 57 50 51 52 53
4c 4d 4e 4f 48 49 4a 4b 44 45 46 47 40 41 42 43
bc bd be bf b8 b9 ba bb b4 b5 b6 b7 b0 b1 b2 b3
ac ad ae af a8 a9 aa ab a4 a5 a6 a7 a0 a1 a2 a3
9c 9d 9e 9f 98 99 9a 9b 94 95 96 97 90 91 92 93
8c 8d 8e 8f 88 89 8a 8b 84 85 86 87 80 81 82 83
fc fd fe ff f8 f9 fa fb f4 f5 f6 f7 f0 f1 f2 f3
ec ed ee ef e8 e9 ea eb e4 e5 e6 e7 e0 e1 e2 e3
dc dd de df d8 d9 da db d4 d5 d6 d7 d0 d1 d2 d3
cc cd ce cf c8 c9 ca cb c4 c5 c6 c7 c0 c1 c2 c3
99 98 9b 9a 9d 9c 9f 9e 91 90 93 92 95 94 97 96
89 88 8b 8a 8d 8c 8f 8e 81 80 83 82 85 84 87 86
b9 b8 bb ba bd bc bf be b1 b0 b3 b2 b5 b4 b7 b6
a9 a8 ab aa ad ac af ae a1 a0 a3 a2 a5 a4 a7 a6
d9 d8 db da dd dc df de d1 d0 d3 d2 d5 d4 d7 d6
c9 c8 cb ca cd cc cf ce c1 c0 c3 c2 c5 c4 c7 c6
f9 f8 fb fa fd fc ff fe f1 f0 f3 f2 f5 f4 f7 f6
e9 e8 eb ea ed ec ef ee e1 e0 e3 e2 e5 e4 e7 e6
19 18 1b 1a 1d 1c 1f 1e 11 10 13 12 15 14 17 16
09 08 0b 0a 0d 0c 0f 0e 01 00 03 02 05 04 07 06
39 38 3b 3a 3d 3c 3f 3e 31 30 33 32 35 34 37 36
29 28 2b 2a 2d 2c 2f 2e 21 20 23 22 25 24 27 26
59 58 5b 5a 5d 5c 5f 5e 51 50 53 52 55 54 57 56
49 48 4b 4a 4d 4c 4f 4e 41 40 43 42 45 44 47 46
79 78 7b 7a 7d 7c 7f 7e 71 70 73 72 75 74 77 76
69 68 6b 6a 6d 6c 6f 6e 61 60 63 62 65 64 67 66
0ff ff

// File: project.f
logic/sd_test_pkg.sv
logic/uart_tx.sv
logic/sector_buffer.sv
logic/sd_spi_ctrl.sv
logic/sector_sequencer.sv
logic/sd_dump_top.sv
tb/sd_card_model.sv
tb/tb_sd_dump.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the SD dump testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f project.f --top-module tb_sd_dump -o sim_tb_sd_dump
if [ $? -ne 0 ]; then
   echo "Build failed"
   exit 1
fi

output=$(./obj_dir/sim_tb_sd_dump)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Verification passed"; then
   exit 0
fi
exit 1

// File: tb/tb_sd_dump.sv
`timescale 1ns/100ps

module tb_sd_dump;

   localparam int                     CLKS_PER_BIT = 4;
   localparam int                     SPI_DIV      = 2;
   localparam sd_test_pkg::sd_index_t TEST_INDEX   = 9'h0FF;
   localparam sd_test_pkg::sd_byte_t  TEST_BYTE    = 8'hFF;
   localparam int LIMIT = 2 * 512 * 10 * CLKS_PER_BIT
                        + 3 * 512 * 8 * 2 * SPI_DIV * 2 + 20000;

   logic clk, reset, uart_txd, sd_cs, sd_sclk, sd_mosi, sd_miso, done, sd_error;

   logic [8:0]            stim [0:513];
   sd_test_pkg::sd_byte_t patched [0:511];
   sd_test_pkg::sd_byte_t rx_q [$];
   int                    cycles, checks, errors, tests, test_checks, test_errors;
   logic                  err_seen, frame_err;

   sd_dump_top #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .SPI_DIV      (SPI_DIV),
      .SECTOR       (32'd0),
      .TEST_INDEX   (TEST_INDEX),
      .TEST_BYTE    (TEST_BYTE)
   ) i_dut (
      .clk      (clk),
      .reset    (reset),
      .uart_txd (uart_txd),
      .sd_cs    (sd_cs),
      .sd_sclk  (sd_sclk),
      .sd_mosi  (sd_mosi),
      .sd_miso  (sd_miso),
      .done     (done),
      .sd_error (sd_error)
   );

   sd_card_model i_card (
      .sd_cs   (sd_cs),
      .sd_sclk (sd_sclk),
      .sd_mosi (sd_mosi),
      .sd_miso (sd_miso)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = !clk;
   end

   //////////////////////////////////////////////////
   // Compare tasks and reporting
   //////////////////////////////////////////////////

   task automatic compare_byte(input string name, input sd_test_pkg::sd_byte_t exp,
                               input sd_test_pkg::sd_byte_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %02h, actual %02h", name, exp, act);
      end
   endtask

   task automatic compare_index(input string name, input sd_test_pkg::sd_index_t exp,
                                input sd_test_pkg::sd_index_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %03h, actual %03h", name, exp, act);
      end
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("Mismatch in %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic compare_count(input string name, input int exp, input int act);
      checks++;
      if (act != exp) begin
         errors++;
         $display("Mismatch in %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic report_test(input string name);
      tests++;
      $display("Test %s: %0d checks, %0d errors", name, checks - test_checks,
               errors - test_errors);
      test_checks = checks;
      test_errors = errors;
   endtask

   //////////////////////////////////////////////////
   // Monitors
   //////////////////////////////////////////////////

   initial begin : watchdog
      cycles = 0;
      while (cycles < LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: the run did not finish within %0d cycles", LIMIT);
      $display("Verification failed");
      $finish;
   end

   always @(negedge clk) begin
      if (!reset && sd_error) err_seen = 1'b1;
   end

   // Bits sampled mid-cell on the falling clock edge
   initial begin : uart_capture
      sd_test_pkg::sd_byte_t b;
      b = '0;
      forever begin
         @(negedge clk);
         if (!reset && uart_txd === 1'b0) begin
            repeat (CLKS_PER_BIT / 2) @(negedge clk);
            if (uart_txd !== 1'b0) frame_err = 1'b1;
            for (int k = 0; k < 8; k++) begin
               repeat (CLKS_PER_BIT) @(negedge clk);
               b = {uart_txd, b[7:1]};
            end
            repeat (CLKS_PER_BIT) @(negedge clk);
            if (uart_txd !== 1'b1) frame_err = 1'b1;
            rx_q.push_back(b);
         end
      end
   end

   //////////////////////////////////////////////////
   // Test flow
   //////////////////////////////////////////////////

   initial begin : main
      sd_test_pkg::sd_index_t diff_index;
      logic                   line_idle;
      reset       = 1'b1;
      checks      = 0;
      errors      = 0;
      tests       = 0;
      test_checks = 0;
      test_errors = 0;
      err_seen    = 1'b0;
      frame_err   = 1'b0;
      $readmemh("tb/sd_stim.txt", stim);

      // File parameters must match the DUT build
      compare_index("stim_test_index", TEST_INDEX, stim[512]);
      compare_byte("stim_test_byte", TEST_BYTE, stim[513][7:0]);
      for (int i = 0; i < 512; i++) begin
         patched[i[8:0]] = (i[8:0] == stim[512]) ? stim[513][7:0] : stim[i[9:0]][7:0];
      end
      report_test("stim_file");

      repeat (2) @(posedge clk);
      #1 reset = 1'b0;

      while (rx_q.size() == 0) @(negedge clk);
      compare_flag("sd_error_at_first_byte", 1'b0, sd_error);
      report_test("init_and_read");

      while (done !== 1'b1) @(negedge clk);
      compare_count("bytes_at_done", 1024, rx_q.size());

      for (int i = 0; i < 512; i++) begin
         compare_byte($sformatf("first_dump[%0d]", i), stim[i[9:0]][7:0], rx_q[i]);
      end
      report_test("first_dump");

      for (int i = 0; i < 512; i++) begin
         compare_byte($sformatf("card_sector[%0d]", i), patched[i[8:0]], i_card.mem[i[8:0]]);
      end
      compare_flag("card_protocol_error", 1'b0, i_card.proto_error);
      report_test("write_back");

      diff_index = 'x;
      for (int i = 0; i < 512; i++) begin
         compare_byte($sformatf("second_dump[%0d]", i), patched[i[8:0]], rx_q[512 + i]);
         if (rx_q[512 + i] !== rx_q[i]) diff_index = i[8:0];
      end
      compare_index("patched_position", stim[512], diff_index);
      report_test("second_dump");

      line_idle = 1'b1;
      repeat (2 * 10 * CLKS_PER_BIT) begin
         @(negedge clk);
         if (uart_txd !== 1'b1) line_idle = 1'b0;
      end
      compare_flag("uart_idle_after_done", 1'b1, line_idle);
      compare_flag("uart_framing_error", 1'b0, frame_err);
      compare_count("bytes_after_done", 1024, rx_q.size());
      compare_flag("sd_error_seen", 1'b0, err_seen);
      report_test("completion");

      $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
      if (errors == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: tb/sd_card_model.sv
`timescale 1ns/100ps

module sd_card_model #(
   parameter string                 STIM_FILE  = "tb/sd_stim.txt",
   parameter sd_test_pkg::sd_addr_t BLOCK_ADDR = '0
) (
   input  logic sd_cs,
   input  logic sd_sclk,
   input  logic sd_mosi,
   output logic sd_miso
);

   typedef enum int {M_CMD, M_WTOKEN, M_WDATA} card_mode_t;

   // Sector image, later checked by the testbench
   sd_test_pkg::sd_byte_t mem [0:511];
   logic                  proto_error;

   logic [8:0]            file_words [0:513];
   sd_test_pkg::sd_byte_t cmd_buf [0:5];
   sd_test_pkg::sd_byte_t out_q [$];
   sd_test_pkg::sd_byte_t rx_sr, out_sr;
   int                    bit_cnt, cmd_cnt, data_cnt, op_tries, idle_clks;
   card_mode_t            mode;

   initial begin
      $readmemh(STIM_FILE, file_words);
      for (int i = 0; i < 512; i++) begin
         mem[i[8:0]] = file_words[i[9:0]][7:0];
      end
      proto_error = 1'b0;
      sd_miso     = 1'b1;
      out_sr      = 8'hFF;
      rx_sr       = 8'hFF;
      bit_cnt     = 0;
      cmd_cnt     = 0;
      data_cnt    = 0;
      op_tries    = 0;
      idle_clks   = 0;
      mode        = M_CMD;
   end

   //////////////////////////////////////////////////
   // Command decode
   //////////////////////////////////////////////////

   task automatic run_command();
      sd_test_pkg::sd_cmd_t  cmd;
      sd_test_pkg::sd_addr_t arg;
      cmd = cmd_buf[0][5:0];
      arg = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
      // Last command byte carries the end bit
      if (cmd_buf[5][0] != 1'b1) proto_error = 1'b1;
      // One fill byte before every R1
      out_q.push_back(8'hFF);
      case (cmd)
         sd_test_pkg::CMD_GO_IDLE: begin
            // Only CMD0 has its CRC checked in SPI mode
            if (cmd_buf[5] != 8'h95) proto_error = 1'b1;
            // At least 80 power-up clocks with CS high
            if (idle_clks < 80) proto_error = 1'b1;
            op_tries = 0;
            out_q.push_back(8'h01);
         end
         sd_test_pkg::CMD_SEND_OP: begin
            op_tries++;
            out_q.push_back((op_tries < 2) ? 8'h01 : 8'h00);
         end
         sd_test_pkg::CMD_READ_BLOCK: begin
            if (arg != {BLOCK_ADDR[22:0], 9'd0}) proto_error = 1'b1;
            out_q.push_back(8'h00);
            out_q.push_back(8'hFF);
            out_q.push_back(sd_test_pkg::DATA_TOKEN);
            for (int i = 0; i < 512; i++) begin
               out_q.push_back(mem[i[8:0]]);
            end
            out_q.push_back(8'hFF);
            out_q.push_back(8'hFF);
         end
         sd_test_pkg::CMD_WRITE_BLOCK: begin
            if (arg != {BLOCK_ADDR[22:0], 9'd0}) proto_error = 1'b1;
            out_q.push_back(8'h00);
            mode = M_WTOKEN;
         end
         default: begin
            // Illegal command
            proto_error = 1'b1;
            out_q.push_back(8'h04);
         end
      endcase
   endtask

   task automatic handle_byte(input sd_test_pkg::sd_byte_t b);
      case (mode)
         M_CMD: begin
            if (cmd_cnt != 0 || b[7:6] == 2'b01) begin
               cmd_buf[cmd_cnt] = b;
               cmd_cnt++;
               if (cmd_cnt == 6) begin
                  cmd_cnt = 0;
                  run_command();
               end
            end
         end
         M_WTOKEN: begin
            if (b == sd_test_pkg::DATA_TOKEN) begin
               mode     = M_WDATA;
               data_cnt = 0;
            end else if (b != 8'hFF) begin
               proto_error = 1'b1;
               mode        = M_CMD;
            end
         end
         default: begin
            if (data_cnt < 512) mem[data_cnt[8:0]] = b;
            data_cnt++;
            // Two CRC bytes end the block, then accept and a short busy
            if (data_cnt == 514) begin
               out_q.push_back(8'h05);
               out_q.push_back(8'h00);
               out_q.push_back(8'h00);
               out_q.push_back(8'h00);
               mode = M_CMD;
            end
         end
      endcase
   endtask

   //////////////////////////////////////////////////
   // SPI mode 0 pins
   //////////////////////////////////////////////////

   always @(posedge sd_sclk) begin
      if (!sd_cs) begin
         rx_sr = {rx_sr[6:0], sd_mosi};
         bit_cnt++;
      end else begin
         idle_clks++;
      end
   end

   always @(negedge sd_sclk) begin
      if (!sd_cs) begin
         if (bit_cnt == 8) begin
            handle_byte(rx_sr);
            bit_cnt = 0;
            out_sr  = (out_q.size() > 0) ? out_q.pop_front() : 8'hFF;
         end else begin
            out_sr = {out_sr[6:0], 1'b1};
         end
         sd_miso = out_sr[7];
      end
   end

   always @(posedge sd_cs) begin
      bit_cnt = 0;
      out_sr  = 8'hFF;
      sd_miso = 1'b1;
   end

endmodule

// File: logic/sd_dump_top.sv
`timescale 1ns/100ps

module sd_dump_top #(
   parameter int                     CLKS_PER_BIT = 434,
   parameter int                     SPI_DIV      = 64,
   parameter sd_test_pkg::sd_addr_t  SECTOR       = '0,
   parameter sd_test_pkg::sd_index_t TEST_INDEX   = 9'h0FF,
   parameter sd_test_pkg::sd_byte_t  TEST_BYTE    = 8'hFF
) (
   input  logic clk,
   input  logic reset,
   output logic uart_txd,
   output logic sd_cs,
   output logic sd_sclk,
   output logic sd_mosi,
   input  logic sd_miso,
   output logic done,
   output logic sd_error
);

   logic                   tx_valid, tx_ready, cmd_valid, cmd_write, cmd_ready, buf_we;
   sd_test_pkg::sd_byte_t  tx_data, buf_wdata, buf_rdata;
   sd_test_pkg::sd_index_t buf_index;

   sector_sequencer #(
      .TEST_INDEX (TEST_INDEX),
      .TEST_BYTE  (TEST_BYTE)
   ) i_seq (
      .clk       (clk),
      .reset     (reset),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .tx_data   (tx_data),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_ready (cmd_ready),
      .buf_index (buf_index),
      .buf_wdata (buf_wdata),
      .buf_we    (buf_we),
      .buf_rdata (buf_rdata),
      .done      (done)
   );

   uart_tx #(
      .CLKS_PER_BIT (CLKS_PER_BIT)
   ) i_uart (
      .clk      (clk),
      .reset    (reset),
      .tx_valid (tx_valid),
      .tx_ready (tx_ready),
      .tx_data  (tx_data),
      .txd      (uart_txd)
   );

   sd_spi_ctrl #(
      .SPI_DIV (SPI_DIV),
      .SECTOR  (SECTOR)
   ) i_sd (
      .clk       (clk),
      .reset     (reset),
      .cmd_valid (cmd_valid),
      .cmd_write (cmd_write),
      .cmd_ready (cmd_ready),
      .sd_error  (sd_error),
      .buf_index (buf_index),
      .buf_wdata (buf_wdata),
      .buf_we    (buf_we),
      .buf_rdata (buf_rdata),
      .sd_cs     (sd_cs),
      .sd_sclk   (sd_sclk),
      .sd_mosi   (sd_mosi),
      .sd_miso   (sd_miso)
   );

endmodule

// File: logic/sector_sequencer.sv
`timescale 1ns/100ps

module sector_sequencer #(
   parameter sd_test_pkg::sd_index_t TEST_INDEX = 9'h0FF,
   parameter sd_test_pkg::sd_byte_t  TEST_BYTE  = 8'hFF
) (
   input  logic                   clk,
   input  logic                   reset,
   output logic                   tx_valid,
   input  logic                   tx_ready,
   output sd_test_pkg::sd_byte_t  tx_data,
   output logic                   cmd_valid,
   output logic                   cmd_write,
   input  logic                   cmd_ready,
   output sd_test_pkg::sd_index_t buf_index,
   output sd_test_pkg::sd_byte_t  buf_wdata,
   output logic                   buf_we,
   input  sd_test_pkg::sd_byte_t  buf_rdata,
   output logic                   done
);

   sd_test_pkg::seq_state_t state, ret_state;

   // Index is stable while the byte is offered to the UART
   assign tx_data   = buf_rdata;
   assign buf_wdata = TEST_BYTE;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= sd_test_pkg::WAIT_INIT;
         ret_state <= sd_test_pkg::PATCH_BYTE;
         tx_valid  <= 1'b0;
         cmd_valid <= 1'b0;
         cmd_write <= 1'b0;
         buf_index <= '0;
         buf_we    <= 1'b0;
         done      <= 1'b0;
      end else begin
         buf_we <= 1'b0;
         case (state)
            //////////////////////////////////////////////////
            // Sector dump over the UART
            //////////////////////////////////////////////////
            sd_test_pkg::SEND_BYTE: begin
               tx_valid <= 1'b1;
               state    <= sd_test_pkg::WAIT_UART;
            end
            sd_test_pkg::WAIT_UART: begin
               if (tx_valid && tx_ready) begin
                  tx_valid <= 1'b0;
               end else if (!tx_valid && tx_ready) begin
                  state <= sd_test_pkg::NEXT_BYTE;
               end
            end
            sd_test_pkg::NEXT_BYTE: begin
               if (buf_index == 9'h1FF) begin
                  state <= ret_state;
                  done  <= (ret_state == sd_test_pkg::STOP);
               end else begin
                  buf_index <= buf_index + 9'd1;
                  state     <= sd_test_pkg::SEND_BYTE;
               end
            end
            //////////////////////////////////////////////////
            // Card commands
            //////////////////////////////////////////////////
            sd_test_pkg::WAIT_INIT, sd_test_pkg::RELOAD: begin
               // Held until initialization or the write-back ends
               cmd_write <= 1'b0;
               if (cmd_valid && cmd_ready) begin
                  cmd_valid <= 1'b0;
                  state     <= sd_test_pkg::WAIT_READ;
               end else begin
                  cmd_valid <= 1'b1;
                  ret_state <= (state == sd_test_pkg::RELOAD) ?
                               sd_test_pkg::STOP : sd_test_pkg::PATCH_BYTE;
               end
            end
            sd_test_pkg::WAIT_READ: begin
               if (cmd_ready) begin
                  buf_index <= '0;
                  state     <= sd_test_pkg::SEND_BYTE;
               end
            end
            sd_test_pkg::PATCH_BYTE: begin
               buf_index <= TEST_INDEX;
               buf_we    <= 1'b1;
               state     <= sd_test_pkg::WRITE_BACK;
            end
            sd_test_pkg::WRITE_BACK: begin
               cmd_write <= 1'b1;
               if (cmd_valid && cmd_ready) begin
                  cmd_valid <= 1'b0;
                  state     <= sd_test_pkg::WAIT_WRITE;
               end else begin
                  cmd_valid <= 1'b1;
               end
            end
            sd_test_pkg::WAIT_WRITE: begin
               if (cmd_ready) begin
                  state <= sd_test_pkg::RELOAD;
               end
            end
            default: state <= sd_test_pkg::STOP;
         endcase
      end
   end

endmodule

// File: logic/sd_spi_ctrl.sv
`timescale 1ns/100ps

module sd_spi_ctrl #(
   parameter int                    SPI_DIV = 64,
   parameter sd_test_pkg::sd_addr_t SECTOR  = '0
) (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   cmd_valid,
   input  logic                   cmd_write,
   output logic                   cmd_ready,
   output logic                   sd_error,
   input  sd_test_pkg::sd_index_t buf_index,
   input  sd_test_pkg::sd_byte_t  buf_wdata,
   input  logic                   buf_we,
   output sd_test_pkg::sd_byte_t  buf_rdata,
   output logic                   sd_cs,
   output logic                   sd_sclk,
   output logic                   sd_mosi,
   input  logic                   sd_miso
);

   localparam int DIV_W = $clog2(SPI_DIV + 1);

   typedef enum logic [3:0] {
      ST_POWER, ST_CMD, ST_RESP, ST_IDLE, ST_RTOKEN, ST_RDATA,
      ST_CRC, ST_WTOKEN, ST_WDATA, ST_WRESP, ST_WBUSY
   } ctrl_state_t;

   ctrl_state_t           state;
   logic [9:0]            cnt;
   sd_test_pkg::sd_cmd_t  cur_cmd;
   sd_test_pkg::sd_addr_t cmd_arg;
   sd_test_pkg::sd_byte_t cmd_byte, tx_byte, tx_sr, rx_sr, b_rdata;
   logic                  spi_busy, spi_done, sclk_q, launch, b_we;
   logic [DIV_W-1:0]      div_cnt;
   logic [2:0]            bit_cnt;

   assign cmd_ready = (state == ST_IDLE);
   assign sd_cs     = (state == ST_POWER) || (state == ST_IDLE);
   assign sd_sclk   = sclk_q;
   assign sd_mosi   = tx_sr[7];

   // Next byte goes out one cycle after the previous one is handled
   assign launch = (state != ST_IDLE) && !spi_busy && !spi_done;

   // Read data lands in the buffer as each byte completes
   assign b_we = (state == ST_RDATA) && spi_done;

   //////////////////////////////////////////////////
   // Outgoing byte selection
   //////////////////////////////////////////////////

   // Block commands carry a byte address
   assign cmd_arg = (cur_cmd == sd_test_pkg::CMD_READ_BLOCK ||
                     cur_cmd == sd_test_pkg::CMD_WRITE_BLOCK) ? {SECTOR[22:0], 9'd0} : '0;

   always_comb begin
      case (cnt[2:0])
         3'd0:    cmd_byte = {2'b01, cur_cmd};
         3'd1:    cmd_byte = cmd_arg[31:24];
         3'd2:    cmd_byte = cmd_arg[23:16];
         3'd3:    cmd_byte = cmd_arg[15:8];
         3'd4:    cmd_byte = cmd_arg[7:0];
         default: cmd_byte = 8'h95;
      endcase
   end

   always_comb begin
      case (state)
         ST_CMD:    tx_byte = cmd_byte;
         ST_WTOKEN: tx_byte = sd_test_pkg::DATA_TOKEN;
         ST_WDATA:  tx_byte = b_rdata;
         default:   tx_byte = 8'hFF;
      endcase
   end

   //////////////////////////////////////////////////
   // SPI byte shifter, mode 0
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         spi_busy <= 1'b0;
         spi_done <= 1'b0;
         sclk_q   <= 1'b0;
         div_cnt  <= '0;
         bit_cnt  <= '0;
         tx_sr    <= '1;
      end else begin
         spi_done <= 1'b0;
         if (launch) begin
            tx_sr    <= tx_byte;
            spi_busy <= 1'b1;
            div_cnt  <= '0;
            bit_cnt  <= '0;
         end else if (spi_busy) begin
            if (div_cnt == DIV_W'(SPI_DIV - 1)) begin
               div_cnt <= '0;
               sclk_q  <= !sclk_q;
               // Falling edge moves MOSI to the next bit
               if (sclk_q) begin
                  tx_sr   <= {tx_sr[6:0], 1'b1};
                  bit_cnt <= bit_cnt + 3'd1;
                  if (bit_cnt == 3'd7) begin
                     spi_busy <= 1'b0;
                     spi_done <= 1'b1;
                  end
               end
            end else begin
               div_cnt <= div_cnt + DIV_W'(1);
            end
         end
      end
   end

   // MISO sampled on the rising edge
   always_ff @(posedge clk) begin
      if (spi_busy && !sclk_q && div_cnt == DIV_W'(SPI_DIV - 1)) begin
         rx_sr <= {rx_sr[6:0], sd_miso};
      end
   end

   //////////////////////////////////////////////////
   // Command FSM
   //////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= ST_POWER;
         cnt      <= '0;
         cur_cmd  <= sd_test_pkg::CMD_GO_IDLE;
         sd_error <= 1'b0;
      end else if (state == ST_IDLE) begin
         if (cmd_valid) begin
            cur_cmd <= cmd_write ? sd_test_pkg::CMD_WRITE_BLOCK : sd_test_pkg::CMD_READ_BLOCK;
            cnt     <= '0;
            state   <= ST_CMD;
         end
      end else if (launch && state == ST_WDATA) begin
         // Count on launch so port B prefetches the next byte
         cnt <= cnt + 10'd1;
      end else if (spi_done) begin
         case (state)
            ST_POWER, ST_CMD, ST_RDATA, ST_CRC: begin
               cnt <= cnt + 10'd1;
               if (state == ST_POWER && cnt == 10'd9) begin
                  cnt   <= '0;
                  state <= ST_CMD;
               end else if (state == ST_CMD && cnt == 10'd5) begin
                  cnt   <= '0;
                  state <= ST_RESP;
               end else if (state == ST_RDATA && cnt == 10'd511) begin
                  cnt   <= '0;
                  state <= ST_CRC;
               end else if (state == ST_CRC && cnt == 10'd1) begin
                  cnt   <= '0;
                  state <= (cur_cmd == sd_test_pkg::CMD_WRITE_BLOCK) ? ST_WRESP : ST_IDLE;
               end
            end
            ST_RESP: begin
               if (rx_sr != 8'hFF) begin
                  case (cur_cmd)
                     sd_test_pkg::CMD_GO_IDLE: begin
                        // Retry CMD0 until the card reports idle
                        if (rx_sr == 8'h01) begin
                           cur_cmd <= sd_test_pkg::CMD_SEND_OP;
                        end
                        state <= ST_CMD;
                     end
                     sd_test_pkg::CMD_SEND_OP: begin
                        if (rx_sr == 8'h00) begin
                           state <= ST_IDLE;
                        end else if (rx_sr == 8'h01) begin
                           state <= ST_CMD;
                        end else begin
                           sd_error <= 1'b1;
                           state    <= ST_IDLE;
                        end
                     end
                     default: begin
                        if (rx_sr != 8'h00) begin
                           sd_error <= 1'b1;
                           state    <= ST_IDLE;
                        end else if (cur_cmd == sd_test_pkg::CMD_READ_BLOCK) begin
                           state <= ST_RTOKEN;
                        end else begin
                           state <= ST_WTOKEN;
                        end
                     end
                  endcase
               end
            end
            ST_RTOKEN: begin
               if (rx_sr == sd_test_pkg::DATA_TOKEN) begin
                  state <= ST_RDATA;
               end else if (rx_sr != 8'hFF) begin
                  sd_error <= 1'b1;
                  state    <= ST_IDLE;
               end
            end
            ST_WTOKEN: state <= ST_WDATA;
            ST_WDATA: begin
               if (cnt == 10'd512) begin
                  cnt   <= '0;
                  state <= ST_CRC;
               end
            end
            ST_WRESP: begin
               // Data response xxx00101 means accepted, it follows the CRC directly
               if (rx_sr[4:0] == 5'b00101) begin
                  state <= ST_WBUSY;
               end else begin
                  sd_error <= 1'b1;
                  state    <= ST_IDLE;
               end
            end
            ST_WBUSY: begin
               if (rx_sr == 8'hFF) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   // Sequencer writes only land while the controller is idle
   sector_buffer i_buf (
      .clk     (clk),
      .a_index (buf_index),
      .a_wdata (buf_wdata),
      .a_we    (buf_we && cmd_ready),
      .a_rdata (buf_rdata),
      .b_index (cnt[8:0]),
      .b_wdata (rx_sr),
      .b_we    (b_we),
      .b_rdata (b_rdata)
   );

endmodule

// File: logic/sector_buffer.sv
`timescale 1ns/100ps

module sector_buffer (
   input  logic                   clk,
   input  sd_test_pkg::sd_index_t a_index,
   input  sd_test_pkg::sd_byte_t  a_wdata,
   input  logic                   a_we,
   output sd_test_pkg::sd_byte_t  a_rdata,
   input  sd_test_pkg::sd_index_t b_index,
   input  sd_test_pkg::sd_byte_t  b_wdata,
   input  logic                   b_we,
   output sd_test_pkg::sd_byte_t  b_rdata
);

   // One 512 byte sector image
   sd_test_pkg::sd_byte_t mem [0:511];

   always_ff @(posedge clk) begin
      if (a_we) begin
         mem[a_index] <= a_wdata;
      end
      // Card side wins on a same-address collision
      if (b_we) begin
         mem[b_index] <= b_wdata;
      end
      a_rdata <= mem[a_index];
      b_rdata <= mem[b_index];
   end

endmodule

// File: logic/uart_tx.sv
`timescale 1ns/100ps

module uart_tx #(
   parameter int CLKS_PER_BIT = 434
) (
   input  logic                 clk,
   input  logic                 reset,
   input  logic                 tx_valid,
   output logic                 tx_ready,
   input  sd_test_pkg::sd_byte_t tx_data,
   output logic                 txd
);

   localparam int CNT_W = $clog2(CLKS_PER_BIT);

   logic             busy;
   logic [CNT_W-1:0] clk_cnt;
   logic [3:0]       bit_cnt;
   // Stop bit, data LSB first, start bit in position 0
   logic [9:0]       frame;

   assign tx_ready = !busy;
   assign txd      = frame[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         busy    <= 1'b0;
         clk_cnt <= '0;
         bit_cnt <= '0;
         frame   <= '1;
      end else if (!busy) begin
         if (tx_valid) begin
            frame   <= {1'b1, tx_data, 1'b0};
            busy    <= 1'b1;
            clk_cnt <= '0;
            bit_cnt <= '0;
         end
      end else if (clk_cnt == CNT_W'(CLKS_PER_BIT - 1)) begin
         // End of one bit time, shift in idle level
         clk_cnt <= '0;
         frame   <= {1'b1, frame[9:1]};
         bit_cnt <= bit_cnt + 4'd1;
         if (bit_cnt == 4'd9) begin
            busy <= 1'b0;
         end
      end else begin
         clk_cnt <= clk_cnt + CNT_W'(1);
      end
   end

endmodule

// File: logic/sd_test_pkg.sv
package sd_test_pkg;

   //////////////////////////////////////////////////
   // Vector types
   //////////////////////////////////////////////////

   typedef logic [7:0]  sd_byte_t;
   typedef logic [8:0]  sd_index_t;
   typedef logic [31:0] sd_addr_t;
   typedef logic [5:0]  sd_cmd_t;

   // SD command indices used in SPI mode
   localparam sd_cmd_t CMD_GO_IDLE     = 6'd0;
   localparam sd_cmd_t CMD_SEND_OP     = 6'd1;
   localparam sd_cmd_t CMD_READ_BLOCK  = 6'd17;
   localparam sd_cmd_t CMD_WRITE_BLOCK = 6'd24;

   // Start of a single data block
   localparam sd_byte_t DATA_TOKEN = 8'hFE;

   // Test sequencer states
   typedef enum logic [3:0] {
      WAIT_INIT,
      SEND_BYTE,
      WAIT_UART,
      NEXT_BYTE,
      PATCH_BYTE,
      WRITE_BACK,
      WAIT_WRITE,
      RELOAD,
      WAIT_READ,
      STOP
   } seq_state_t;

endpackage
